// ==== mdu_unit.f ====
design/mdu_pkg.sv
design/mdu_tag_table.sv
design/mdu_mul_pipe.sv
design/mdu_serial_div.sv
design/mdu_unit.sv
dv/mdu_clk_gen.sv
dv/mdu_checker.sv
dv/mdu_tb.sv

// ==== Bender.yml ====
package:
  name: mdu_unit

sources:
  - design/mdu_pkg.sv
  - design/mdu_tag_table.sv
  - design/mdu_mul_pipe.sv
  - design/mdu_serial_div.sv
  - design/mdu_unit.sv
  - target: test
    files:
      - dv/mdu_clk_gen.sv
      - dv/mdu_checker.sv
      - dv/mdu_tb.sv

// ==== dv/mdu_tb.sv ====
module mdu_tb
    import mdu_pkg::*;
();

    localparam int MAX_ENTRIES = 48;
    localparam int N_RANDOM    = 24;

    logic                           clk;
    logic                           arst_n;
    logic                           req_valid;
    logic                           req_ready;
    mdu_op_e                        req_op;
    logic [NUM_LANES-1:0][XLEN-1:0] req_rs1;
    logic [NUM_LANES-1:0][XLEN-1:0] req_rs2;
    logic [NW_BITS-1:0]             req_wid;
    logic [NUM_LANES-1:0]           req_tmask;
    logic [XLEN-1:0]                req_pc;
    logic [NR_BITS-1:0]             req_rd;
    logic                           req_wb;
    logic [127:0]                   req_name;
    logic                           cmt_valid;
    logic                           cmt_ready;
    logic [NW_BITS-1:0]             cmt_wid;
    logic [NUM_LANES-1:0]           cmt_tmask;
    logic [XLEN-1:0]                cmt_pc;
    logic [NR_BITS-1:0]             cmt_rd;
    logic                           cmt_wb;
    logic [NUM_LANES-1:0][XLEN-1:0] cmt_data;
    int                             pending;

    logic [127:0]                   t_name  [MAX_ENTRIES];
    mdu_op_e                        t_op    [MAX_ENTRIES];
    logic [NUM_LANES-1:0][XLEN-1:0] t_rs1   [MAX_ENTRIES];
    logic [NUM_LANES-1:0][XLEN-1:0] t_rs2   [MAX_ENTRIES];
    logic [NUM_LANES-1:0]           t_tmask [MAX_ENTRIES];
    int                             n_entries    = 0;
    int                             n_directed   = 0;
    logic [15:0]                    lfsr_state   = 16'd64;
    logic                           random_phase = 1'b0;
    logic                           table_ready  = 1'b0;

    mdu_clk_gen clk_gen_i (.clk(clk), .arst_n(arst_n));

    mdu_unit dut_i (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
        .req_rs1(req_rs1), .req_rs2(req_rs2), .req_wid(req_wid), .req_tmask(req_tmask),
        .req_pc(req_pc), .req_rd(req_rd), .req_wb(req_wb),
        .cmt_valid(cmt_valid), .cmt_ready(cmt_ready), .cmt_wid(cmt_wid),
        .cmt_tmask(cmt_tmask), .cmt_pc(cmt_pc), .cmt_rd(cmt_rd), .cmt_wb(cmt_wb),
        .cmt_data(cmt_data)
    );

    mdu_checker chk_i (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
        .req_rs1(req_rs1), .req_rs2(req_rs2), .req_wid(req_wid), .req_tmask(req_tmask),
        .req_pc(req_pc), .req_rd(req_rd), .req_wb(req_wb), .req_name(req_name),
        .cmt_valid(cmt_valid), .cmt_ready(cmt_ready), .cmt_wid(cmt_wid),
        .cmt_tmask(cmt_tmask), .cmt_pc(cmt_pc), .cmt_rd(cmt_rd), .cmt_wb(cmt_wb),
        .cmt_data(cmt_data), .pending(pending)
    );

    // Taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    task automatic add_entry(input logic [127:0] name, input mdu_op_e op,
                             input logic [XLEN-1:0] a0, input logic [XLEN-1:0] a1,
                             input logic [XLEN-1:0] b0, input logic [XLEN-1:0] b1,
                             input logic [NUM_LANES-1:0] tmask);
        t_name[n_entries]  = name;
        t_op[n_entries]    = op;
        t_rs1[n_entries]   = {a1, a0};
        t_rs2[n_entries]   = {b1, b0};
        t_tmask[n_entries] = tmask;
        n_entries++;
    endtask

    task automatic build_table();
        logic [2:0] op_bits;
        add_entry("mul_basic", OP_MUL, 7, -3, 6, 5, 2'b11);
        add_entry("mul_wrap", OP_MUL, 32'h8000_0000, 32'h1234_5678, 32'hFFFF_FFFF,
                  32'h9ABC_DEF0, 2'b01);
        add_entry("mulh_extremes", OP_MULH, 32'h8000_0000, 32'h7FFF_FFFF, 32'h8000_0000,
                  32'hFFFF_FFFF, 2'b11);
        add_entry("mulhsu_extremes", OP_MULHSU, 32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF,
                  32'h0000_0002, 2'b10);
        add_entry("mulhu_extremes", OP_MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
                  32'h8000_0000, 2'b11);
        add_entry("div_mixed", OP_DIV, -7, 7, 2, -2, 2'b11);
        add_entry("divu_mixed", OP_DIVU, 32'hFFFF_FFF0, 100, 3, 7, 2'b11);
        add_entry("rem_mixed", OP_REM, -7, 7, 2, -2, 2'b11);
        add_entry("remu_mixed", OP_REMU, 32'hFFFF_FFF0, 100, 3, 7, 2'b10);
        add_entry("div_by_zero", OP_DIV, -5, 9, 0, 0, 2'b11);
        add_entry("divu_by_zero", OP_DIVU, 32'hFFFF_FFFF, 1, 0, 0, 2'b11);
        add_entry("rem_by_zero", OP_REM, -5, 9, 0, 0, 2'b01);
        add_entry("remu_by_zero", OP_REMU, 32'hFFFF_FFFF, 1, 0, 0, 2'b11);
        add_entry("div_overflow", OP_DIV, 32'h8000_0000, 32'h8000_0000, -1, 1, 2'b11);
        add_entry("rem_overflow", OP_REM, 32'h8000_0000, 32'h8000_0000, -1, 1, 2'b11);
        add_entry("div_then_mul", OP_DIVU, 1000, 77, 10, 3, 2'b01);
        add_entry("mul_overtakes", OP_MULH, 32'h7FFF_FFFF, -2, 32'h7FFF_FFFF, 3, 2'b11);
        // With the divide still running, the next two multiplies take the last free tags.
        add_entry("fill_tags_mul", OP_MUL, 32'hDEAD_BEEF, 12345, 3, -9, 2'b11);
        add_entry("fill_tags_mulhu", OP_MULHU, 32'h8000_0001, 32'hFFFF_0000, 32'h0001_0000,
                  32'hFFFF_FFFE, 2'b10);
        add_entry("wait_free_tag", OP_MULHSU, -1, 32'h7FFF_FFFF, 32'hFFFF_FFFF,
                  32'h8000_0000, 2'b11);
        n_directed = n_entries;
        for (int i = 0; i < N_RANDOM; i++) begin
            op_bits = take_bits(3);
            add_entry("random", mdu_op_e'(op_bits), take_bits(32), take_bits(32),
                      take_bits(32), take_bits(32), take_bits(NUM_LANES));
        end
    endtask

    initial begin
        cmt_ready = 1'b1;
        forever begin
            @(posedge clk);
            cmt_ready <= random_phase ? take_bits(1) : 1'b1;
        end
    end

    initial begin
        int total;
        req_valid = 1'b0;
        req_op    = OP_MUL;
        req_rs1   = '0;
        req_rs2   = '0;
        req_wid   = '0;
        req_tmask = '0;
        req_pc    = '0;
        req_rd    = '0;
        req_wb    = 1'b0;
        req_name  = '0;
        build_table();
        table_ready = 1'b1;
        wait (arst_n === 1'b1);
        @(posedge clk);
        for (int i = 0; i < n_entries; i++) begin
            if (i == n_directed) begin
                random_phase <= 1'b1;
            end
            req_valid <= 1'b1;
            req_op    <= t_op[i];
            req_rs1   <= t_rs1[i];
            req_rs2   <= t_rs2[i];
            req_tmask <= t_tmask[i];
            req_name  <= t_name[i];
            req_rd    <= NR_BITS'(i); // Unique while a request is in flight.
            req_wid   <= NW_BITS'(i);
            req_pc    <= XLEN'(32'h0000_1000 + 4 * i);
            req_wb    <= (i % 3 != 0);
            @(posedge clk);
            while (!req_ready) @(posedge clk);
        end
        req_valid    <= 1'b0;
        random_phase <= 1'b0;
        repeat (2) @(posedge clk); // Let the checker count the last request.
        wait (pending == 0);
        repeat (5) @(posedge clk);
        chk_i.finish_report(total);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        int limit;
        int wd_total;
        wait (table_ready);
        limit = n_entries * (XLEN + 10) * 10;
        #(limit);
        $display("Timeout after %0d time units with %0d requests still open.", limit, pending);
        chk_i.finish_report(wd_total);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== dv/mdu_checker.sv ====
module mdu_checker
    import mdu_pkg::*;
(
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           req_valid,
    input  logic                           req_ready,
    input  mdu_op_e                        req_op,
    input  logic [NUM_LANES-1:0][XLEN-1:0] req_rs1,
    input  logic [NUM_LANES-1:0][XLEN-1:0] req_rs2,
    input  logic [NW_BITS-1:0]             req_wid,
    input  logic [NUM_LANES-1:0]           req_tmask,
    input  logic [XLEN-1:0]                req_pc,
    input  logic [NR_BITS-1:0]             req_rd,
    input  logic                           req_wb,
    input  logic [127:0]                   req_name,
    input  logic                           cmt_valid,
    input  logic                           cmt_ready,
    input  logic [NW_BITS-1:0]             cmt_wid,
    input  logic [NUM_LANES-1:0]           cmt_tmask,
    input  logic [XLEN-1:0]                cmt_pc,
    input  logic [NR_BITS-1:0]             cmt_rd,
    input  logic                           cmt_wb,
    input  logic [NUM_LANES-1:0][XLEN-1:0] cmt_data,
    output int                             pending
);

    localparam int NUM_RD = 2 ** NR_BITS;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN - 1){1'b0}}};

    logic [NUM_LANES-1:0][XLEN-1:0]      exp_data  [NUM_RD];
    logic [META_BITS-1:0]                exp_meta  [NUM_RD];
    logic [127:0]                        exp_name  [NUM_RD];
    logic                                exp_mul   [NUM_RD];
    int                                  acc_cycle [NUM_RD];
    logic [NUM_RD-1:0]                   open_q     = '0;
    logic [META_BITS+NUM_LANES*XLEN-1:0] cmt_now;
    logic [META_BITS+NUM_LANES*XLEN-1:0] held_q;
    logic                                held_valid = 1'b0;
    logic                                reset_seen = 1'b0;
    int                                  cycle      = 0;
    int                                  last_stall = -1;
    int                                  data_errs  = 0;
    int                                  meta_errs  = 0;
    int                                  proto_errs = 0;

    assign cmt_now = {cmt_wid, cmt_tmask, cmt_pc, cmt_rd, cmt_wb, cmt_data};

    // Result of one lane by the RISC-V M rules.
    function automatic logic [XLEN-1:0] predict(input mdu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0]      ea;
        logic [2*XLEN-1:0]      eb;
        logic [2*XLEN-1:0]      prod;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        sa = a;
        sb = b;
        ea = (op == OP_MULHU) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
        eb = (op inside {OP_MULHSU, OP_MULHU}) ? {{XLEN{1'b0}}, b} : {{XLEN{b[XLEN-1]}}, b};
        prod = ea * eb; // Modulo 2**64 this is the exact product.
        case (op)
            OP_MUL:  predict = prod[XLEN-1:0];
            OP_DIVU: predict = (b == '0) ? '1 : a / b;
            OP_REMU: predict = (b == '0) ? a : a % b;
            OP_DIV: begin
                if (b == '0) predict = '1;
                else if (a == MOST_NEG && b == '1) predict = a;
                else predict = sa / sb;
            end
            OP_REM: begin
                if (b == '0) predict = a;
                else if (a == MOST_NEG && b == '1) predict = '0;
                else predict = sa % sb;
            end
            default: predict = prod[2*XLEN-1:XLEN];
        endcase
    endfunction

    always @(posedge clk) begin
        if (!arst_n) begin
            pending = 0;
        end else begin
            cycle++;
            if (!reset_seen) begin
                reset_seen = 1'b1;
                if (cmt_valid || !req_ready) begin
                    $display("After reset cmt_valid is %b and req_ready is %b.",
                             cmt_valid, req_ready);
                    proto_errs++;
                end
            end
            if (pending - int'(cmt_valid) >= MULQ_SIZE && req_ready) begin
                $display("req_ready is high while every tag is in use (cycle %0d).", cycle);
                proto_errs++;
            end
            if (held_valid && (!cmt_valid || cmt_now !== held_q)) begin
                $display("Commit outputs changed while cmt_ready was low (cycle %0d).", cycle);
                proto_errs++;
            end
            held_valid = cmt_valid && !cmt_ready;
            held_q     = cmt_now;

            if (cmt_valid && cmt_ready) begin
                if (!open_q[cmt_rd]) begin
                    $display("A commit on rd %0d matches no outstanding request.", cmt_rd);
                    proto_errs++;
                end else begin
                    if (cmt_data !== exp_data[cmt_rd]) begin
                        $display("FAIL %0s rd %0d: data expected %h actual %h",
                                 exp_name[cmt_rd], cmt_rd, exp_data[cmt_rd], cmt_data);
                        data_errs++;
                    end
                    if (cmt_now[META_BITS+NUM_LANES*XLEN-1:NUM_LANES*XLEN]
                            !== exp_meta[cmt_rd]) begin
                        $display("FAIL %0s rd %0d: metadata expected %h actual %h",
                                 exp_name[cmt_rd], cmt_rd, exp_meta[cmt_rd],
                                 cmt_now[META_BITS+NUM_LANES*XLEN-1:NUM_LANES*XLEN]);
                        meta_errs++;
                    end
                    // Without back-pressure a multiply takes a fixed time.
                    if (exp_mul[cmt_rd] && last_stall < acc_cycle[cmt_rd]
                            && cycle - acc_cycle[cmt_rd] != MUL_LATENCY + 1) begin
                        $display("FAIL %0s rd %0d: latency expected %0d actual %0d",
                                 exp_name[cmt_rd], cmt_rd, MUL_LATENCY + 1,
                                 cycle - acc_cycle[cmt_rd]);
                        proto_errs++;
                    end
                    open_q[cmt_rd] = 1'b0;
                    pending--;
                end
            end

            if (req_valid && req_ready) begin
                if (open_q[req_rd]) begin
                    $display("A request on rd %0d was accepted before the last one committed.",
                             req_rd);
                    proto_errs++;
                end
                for (int l = 0; l < NUM_LANES; l++) begin
                    exp_data[req_rd][l] = predict(req_op, req_rs1[l], req_rs2[l]);
                end
                exp_meta[req_rd]  = {req_wid, req_tmask, req_pc, req_rd, req_wb};
                exp_name[req_rd]  = req_name;
                exp_mul[req_rd]   = req_op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
                acc_cycle[req_rd] = cycle;
                open_q[req_rd]    = 1'b1;
                pending++;
            end

            if (!cmt_ready) begin
                last_stall = cycle;
            end
        end
    end

    task automatic finish_report(output int total);
        for (int r = 0; r < NUM_RD; r++) begin
            if (open_q[r]) begin
                $display("Request %0s on rd %0d never committed.", exp_name[r], r);
                proto_errs++;
            end
        end
        total = data_errs + meta_errs + proto_errs;
        $display("Errors: data %0d, metadata %0d, protocol %0d", data_errs, meta_errs,
                 proto_errs);
    endtask

endmodule

// ==== dv/mdu_clk_gen.sv ====
module mdu_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1; // Released on a rising edge after five cycles.
    end

endmodule

// ==== design/mdu_unit.sv ====
module mdu_unit
    import mdu_pkg::*;
(
    input  logic                           clk,
    input  logic                           arst_n,

    input  logic                           req_valid,
    output logic                           req_ready,
    input  mdu_op_e                        req_op,
    input  logic [NUM_LANES-1:0][XLEN-1:0] req_rs1,
    input  logic [NUM_LANES-1:0][XLEN-1:0] req_rs2,
    input  logic [NW_BITS-1:0]             req_wid,
    input  logic [NUM_LANES-1:0]           req_tmask,
    input  logic [XLEN-1:0]                req_pc,
    input  logic [NR_BITS-1:0]             req_rd,
    input  logic                           req_wb,

    output logic                           cmt_valid,
    input  logic                           cmt_ready,
    output logic [NW_BITS-1:0]             cmt_wid,
    output logic [NUM_LANES-1:0]           cmt_tmask,
    output logic [XLEN-1:0]                cmt_pc,
    output logic [NR_BITS-1:0]             cmt_rd,
    output logic                           cmt_wb,
    output logic [NUM_LANES-1:0][XLEN-1:0] cmt_data
);

    logic                           is_div_op;
    logic                           is_rem_op;
    logic                           is_signed_div;
    logic                           is_lo;
    logic                           sign_a;
    logic                           sign_b;
    logic                           req_fire;
    logic                           cmt_load;
    logic                           mul_enable;
    logic                           tag_full;
    logic [TAG_BITS-1:0]            new_tag;
    logic [TAG_BITS-1:0]            sel_tag;
    logic [META_BITS-1:0]           sel_meta;
    logic                           mul_valid_out;
    logic [TAG_BITS-1:0]            mul_tag;
    logic [NUM_LANES-1:0][XLEN-1:0] mul_result;
    logic                           div_ready_in;
    logic                           div_ready_out;
    logic                           div_valid_out;
    logic [TAG_BITS-1:0]            div_tag;
    logic [NUM_LANES-1:0][XLEN-1:0] div_result;
    logic                           sel_valid;
    logic [NUM_LANES-1:0][XLEN-1:0] sel_result;

    assign is_div_op     = req_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign is_rem_op     = req_op inside {OP_REM, OP_REMU};
    assign is_signed_div = req_op inside {OP_DIV, OP_REM};
    assign is_lo         = (req_op == OP_MUL);
    assign sign_a        = (req_op != OP_MULHU);
    assign sign_b        = req_op inside {OP_MUL, OP_MULH};

    assign cmt_load   = !cmt_valid || cmt_ready;
    assign mul_enable = cmt_load || !mul_valid_out;
    assign req_ready  = !tag_full && (is_div_op ? div_ready_in : mul_enable);
    assign req_fire   = req_valid && req_ready;

    mdu_tag_table tag_table_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .acquire     (req_fire),
        .wr_meta     ({req_wid, req_tmask, req_pc, req_rd, req_wb}),
        .rd_tag      (sel_tag),
        .release_tag (sel_tag),
        .release_en  (cmt_load && sel_valid),
        .new_tag     (new_tag),
        .rd_meta     (sel_meta),
        .full        (tag_full)
    );

    mdu_mul_pipe mul_pipe_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .enable    (mul_enable),
        .valid_in  (req_fire && !is_div_op),
        .tag_in    (new_tag),
        .lo_in     (is_lo),
        .sign_a    (sign_a),
        .sign_b    (sign_b),
        .a         (req_rs1),
        .b         (req_rs2),
        .valid_out (mul_valid_out),
        .tag_out   (mul_tag),
        .lo_out    (),
        .product   (mul_result)
    );

    assign div_ready_out = cmt_load && !mul_valid_out; // Multiply results go first.

    mdu_serial_div serial_div_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .valid_in    (req_fire && is_div_op),
        .signed_mode (is_signed_div),
        .is_rem_in   (is_rem_op),
        .tag_in      (new_tag),
        .numer       (req_rs1),
        .denom       (req_rs2),
        .ready_out   (div_ready_out),
        .ready_in    (div_ready_in),
        .valid_out   (div_valid_out),
        .is_rem_out  (),
        .tag_out     (div_tag),
        .result      (div_result)
    );

    assign sel_valid  = mul_valid_out || div_valid_out;
    assign sel_tag    = mul_valid_out ? mul_tag : div_tag;
    assign sel_result = mul_valid_out ? mul_result : div_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmt_valid <= 1'b0;
        end else if (cmt_load) begin
            cmt_valid <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmt_load && sel_valid) begin
            {cmt_wid, cmt_tmask, cmt_pc, cmt_rd, cmt_wb} <= sel_meta;
            cmt_data <= sel_result;
        end
    end

    a_cmt_hold: assert property (@(posedge clk) disable iff (!arst_n)
        cmt_valid && !cmt_ready |=> cmt_valid
            && $stable({cmt_wid, cmt_tmask, cmt_pc, cmt_rd, cmt_wb, cmt_data}));

endmodule

// ==== design/mdu_serial_div.sv ====
module mdu_serial_div
    import mdu_pkg::*;
(
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           valid_in,
    input  logic                           signed_mode,
    input  logic                           is_rem_in,
    input  logic [TAG_BITS-1:0]            tag_in,
    input  logic [NUM_LANES-1:0][XLEN-1:0] numer,
    input  logic [NUM_LANES-1:0][XLEN-1:0] denom,
    input  logic                           ready_out,
    output logic                           ready_in,
    output logic                           valid_out,
    output logic                           is_rem_out,
    output logic [TAG_BITS-1:0]            tag_out,
    output logic [NUM_LANES-1:0][XLEN-1:0] result
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_e;

    div_state_e              state_q;
    logic [DIV_CNT_BITS-1:0] cnt_q;
    logic                    is_rem_q;
    logic [TAG_BITS-1:0]     tag_q;
    logic                    accept;

    assign ready_in   = (state_q == IDLE);
    assign accept     = valid_in && ready_in;
    assign valid_out  = (state_q == DONE);
    assign is_rem_out = is_rem_q;
    assign tag_out    = tag_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= RUN;
                        cnt_q   <= '0;
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == DIV_CNT_BITS'(XLEN - 1)) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (ready_out) begin
                        state_q <= IDLE; // Result taken.
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            is_rem_q <= is_rem_in;
            tag_q    <= tag_in;
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [XLEN-1:0] quo_q;
        logic [XLEN-1:0] rem_q;
        logic [XLEN-1:0] den_q;
        logic            neg_quo_q;
        logic            neg_rem_q;
        logic            den_zero_q;
        logic            n_neg;
        logic            d_neg;
        logic [XLEN:0]   shifted;
        logic [XLEN:0]   diff;
        logic [XLEN-1:0] quo_fix;
        logic [XLEN-1:0] rem_fix;

        assign n_neg   = signed_mode & numer[i][XLEN-1];
        assign d_neg   = signed_mode & denom[i][XLEN-1];
        assign shifted = {rem_q, quo_q[XLEN-1]};
        assign diff    = shifted - {1'b0, den_q};

        // The most negative dividend stays 0x80000000 as a magnitude,
        // so the overflow case falls out with remainder zero.
        always_ff @(posedge clk) begin
            if (accept) begin
                quo_q      <= n_neg ? -numer[i] : numer[i];
                den_q      <= d_neg ? -denom[i] : denom[i];
                rem_q      <= '0;
                neg_quo_q  <= n_neg ^ d_neg;
                neg_rem_q  <= n_neg;
                den_zero_q <= (denom[i] == '0);
            end else if (state_q == RUN) begin
                if (!diff[XLEN]) begin
                    rem_q <= diff[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b1};
                end else begin
                    rem_q <= shifted[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b0};
                end
            end
        end

        assign quo_fix   = den_zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
        assign rem_fix   = neg_rem_q ? -rem_q : rem_q; // Gives the dividend back for zero divisors.
        assign result[i] = is_rem_q ? rem_fix : quo_fix;
    end

    a_div_busy_window: assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> ##1 (!ready_in && !valid_out) [*XLEN] ##1 valid_out);

endmodule

// ==== design/mdu_mul_pipe.sv ====
module mdu_mul_pipe
    import mdu_pkg::*;
(
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           enable,
    input  logic                           valid_in,
    input  logic [TAG_BITS-1:0]            tag_in,
    input  logic                           lo_in,
    input  logic                           sign_a,
    input  logic                           sign_b,
    input  logic [NUM_LANES-1:0][XLEN-1:0] a,
    input  logic [NUM_LANES-1:0][XLEN-1:0] b,
    output logic                           valid_out,
    output logic [TAG_BITS-1:0]            tag_out,
    output logic                           lo_out,
    output logic [NUM_LANES-1:0][XLEN-1:0] product
);

    logic [NUM_LANES-1:0][2*XLEN-1:0] prod_d;
    logic [NUM_LANES-1:0][2*XLEN-1:0] prod_q [MUL_LATENCY];
    logic [TAG_BITS-1:0]              tag_q  [MUL_LATENCY];
    logic [MUL_LATENCY-1:0]           valid_q;
    logic [MUL_LATENCY-1:0]           lo_q;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic signed [XLEN:0]     op_a;
        logic signed [XLEN:0]     op_b;
        logic signed [2*XLEN+1:0] full_prod;

        // The extra bit makes one signed multiplier serve all four variants.
        assign op_a      = {sign_a & a[i][XLEN-1], a[i]};
        assign op_b      = {sign_b & b[i][XLEN-1], b[i]};
        assign full_prod = op_a * op_b;
        assign prod_d[i] = full_prod[2*XLEN-1:0];

        assign product[i] = lo_out ? prod_q[MUL_LATENCY-1][i][XLEN-1:0]
                                   : prod_q[MUL_LATENCY-1][i][2*XLEN-1:XLEN];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q <= {valid_q[MUL_LATENCY-2:0], valid_in};
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            prod_q[0] <= prod_d;
            tag_q[0]  <= tag_in;
            lo_q      <= {lo_q[MUL_LATENCY-2:0], lo_in};
            for (int s = 1; s < MUL_LATENCY; s++) begin
                prod_q[s] <= prod_q[s-1];
                tag_q[s]  <= tag_q[s-1];
            end
        end
    end

    assign valid_out = valid_q[MUL_LATENCY-1];
    assign tag_out   = tag_q[MUL_LATENCY-1];
    assign lo_out    = lo_q[MUL_LATENCY-1];

endmodule

// ==== design/mdu_tag_table.sv ====
module mdu_tag_table
    import mdu_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 acquire,
    input  logic [META_BITS-1:0] wr_meta,
    input  logic [TAG_BITS-1:0]  rd_tag,
    input  logic [TAG_BITS-1:0]  release_tag,
    input  logic                 release_en,
    output logic [TAG_BITS-1:0]  new_tag,
    output logic [META_BITS-1:0] rd_meta,
    output logic                 full
);

    logic [MULQ_SIZE-1:0] used_q;
    logic [META_BITS-1:0] meta_mem [MULQ_SIZE];

    always_comb begin
        new_tag = '0;
        for (int i = MULQ_SIZE - 1; i >= 0; i--) begin
            if (!used_q[i]) begin
                new_tag = TAG_BITS'(i); // Lowest free slot wins.
            end
        end
    end

    assign full    = &used_q;
    assign rd_meta = meta_mem[rd_tag];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            used_q <= '0;
        end else begin
            if (release_en) begin
                used_q[release_tag] <= 1'b0;
            end
            if (acquire) begin
                used_q[new_tag] <= 1'b1; // Never the released slot, which is still occupied.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acquire) begin
            meta_mem[new_tag] <= wr_meta;
        end
    end

    a_no_acquire_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        acquire |-> !full);

    a_release_occupied: assert property (@(posedge clk) disable iff (!arst_n)
        release_en |-> used_q[release_tag]);

endmodule

// ==== design/mdu_pkg.sv ====
package mdu_pkg;

    localparam int NUM_LANES    = 2;
    localparam int XLEN         = 32;
    localparam int NW_BITS      = 2;
    localparam int NR_BITS      = 5;
    localparam int MULQ_SIZE    = 4;
    localparam int TAG_BITS     = $clog2(MULQ_SIZE);
    localparam int MUL_LATENCY  = 3;
    localparam int DIV_CNT_BITS = $clog2(XLEN);

    // Warp id, thread mask, PC, rd and wb flag.
    localparam int META_BITS = NW_BITS + NUM_LANES + XLEN + NR_BITS + 1;

    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } mdu_op_e;

endpackage
